//--- src/conv_pkg.sv
/*
  Convolution engine shared definitions.
  User-word bit layout, m_user layout and kernel-width encoding.
*/
package conv_pkg;

  // ----------------------------------------
  // Input user word
  // ----------------------------------------
  localparam int user_w         = 6;
  localparam int i_not_max      = 0;  // Passed through to m_user.
  localparam int i_bottom_block = 1;  // Passed through to m_user.
  localparam int i_cin_last     = 2;  // Closes a group of input channels.
  localparam int i_w_first      = 3;  // Clears the running sums.
  localparam int i_kw2          = 4;  // Kernel width select.
  // Bit 5 is spare and ignored.

  // ----------------------------------------
  // Output user word
  // ----------------------------------------
  localparam int user_out_w     = 2;
  localparam int o_not_max      = 0;
  localparam int o_bottom_block = 1;

  // ----------------------------------------
  // Kernel width
  // ----------------------------------------
  localparam int   kw_max = 3;     // Widest kernel.
  localparam logic kw2_k1 = 1'b0;  // Kernel width 1.
  localparam logic kw2_k3 = 1'b1;  // Kernel width 3.

endpackage

//--- src/delay_line.sv
/*
  Delay line. N clock-enabled register stages over any payload type.
*/
`timescale 1ns/1ps

module delay_line #(
  parameter type payload_t = logic,
  parameter int  N         = 1
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     en,
  input  payload_t d,
  output payload_t q
);

  generate
    if (N == 0) begin : g_pass
      assign q = d;  // No stages.
    end else begin : g_stages
      payload_t stage [N];

      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          for (int i = 0; i < N; i++) begin
            stage[i] <= '0;
          end
        end else if (en) begin
          stage[0] <= d;
          for (int i = 1; i < N; i++) begin
            stage[i] <= stage[i-1];
          end
        end
      end

      assign q = stage[N-1];
    end
  endgenerate

endmodule

//--- src/beat_decode.sv
/*
  Beat decoder. Tracks each beat's flags through the multiplier and
  accumulator stages and sequences the kernel-width-3 drain and shift.
*/
`timescale 1ns/1ps

module beat_decode #(
  parameter int LATENCY_MUL = 2,
  parameter int LATENCY_ACC = 2
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         clken,
  input  logic                         s_valid,
  input  logic                         s_last,
  input  logic [conv_pkg::user_w-1:0]  s_user,
  output logic                         s_ready,
  output logic                         mul_en,
  output logic                         shift_en,
  output logic                         clear_sum,
  output logic                         acc_kw2,
  output logic                         group_done,
  output logic                         done_last,
  output logic [conv_pkg::user_w-1:0]  done_user
);

  localparam int drain_len = LATENCY_MUL + LATENCY_ACC;
  localparam int cnt_w     = $clog2(drain_len + 1);

  typedef struct packed {
    logic                        vld;
    logic                        last;
    logic [conv_pkg::user_w-1:0] user;
  } beat_t;

  typedef enum logic [1:0] {st_run, st_drain, st_shift} state_t;

  state_t                      state;
  logic [cnt_w-1:0]            cnt;
  logic                        done_k3;
  logic                        grp_last;
  logic [conv_pkg::user_w-1:0] grp_user;
  logic                        close_k3;
  logic                        done_k1;
  beat_t                       beat_in;
  beat_t                       mul_q;
  beat_t                       acc_q;

  assign s_ready = clken && (state == st_run);
  assign mul_en  = s_ready && s_valid;  // Beat accepted.
  assign beat_in = '{vld: mul_en, last: s_last, user: s_user};

  // ----------------------------------------
  // Flag pipeline
  // ----------------------------------------
  delay_line #(.payload_t(beat_t), .N(LATENCY_MUL)) mul_dly_i (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (clken),
    .d      (beat_in),
    .q      (mul_q)
  );

  delay_line #(.payload_t(beat_t), .N(LATENCY_ACC)) acc_dly_i (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (clken),
    .d      (mul_q),
    .q      (acc_q)
  );

  assign clear_sum = mul_q.vld && mul_q.user[conv_pkg::i_w_first];

  // Kernel width of the beats entering the accumulators.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_kw2 <= conv_pkg::kw2_k1;
    end else if (clken && acc_q.vld) begin
      acc_kw2 <= acc_q.user[conv_pkg::i_kw2];
    end
  end

  // ----------------------------------------
  // Drain and shift FSM
  // ----------------------------------------
  assign close_k3 = mul_en && s_user[conv_pkg::i_cin_last] &&
                    (s_user[conv_pkg::i_kw2] == conv_pkg::kw2_k3);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_run;
      cnt      <= '0;
      done_k3  <= 1'b0;
      grp_last <= 1'b0;
      grp_user <= '0;
    end else if (clken) begin
      done_k3 <= (state == st_shift);  // One cycle after the shift.
      case (state)
        st_run: begin
          if (close_k3) begin
            state    <= st_drain;
            cnt      <= '0;
            grp_last <= s_last;
            grp_user <= s_user;
          end
        end
        st_drain: begin
          if (cnt == cnt_w'(drain_len - 1)) begin
            state <= st_shift;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_shift: state <= st_run;
        default:  state <= st_run;
      endcase
    end
  end

  assign shift_en = (state == st_shift);

  assign done_k1 = acc_q.vld && acc_q.user[conv_pkg::i_cin_last] &&
                   (acc_q.user[conv_pkg::i_kw2] == conv_pkg::kw2_k1);

  assign group_done = done_k3 || done_k1;
  assign done_last  = done_k3 ? grp_last : acc_q.last;
  assign done_user  = done_k3 ? grp_user : acc_q.user;

endmodule

//--- src/processing_element.sv
/*
  Processing element. Pipelined signed multiply, then accumulate with
  clear on the first weight beat and a neighbor add in the shift cycle.
*/
`timescale 1ns/1ps

module processing_element #(
  parameter int WORD_WIDTH_IN  = 8,
  parameter int WORD_WIDTH_OUT = 24,
  parameter int LATENCY_MUL    = 2,
  parameter int LATENCY_ACC    = 2
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             clken,
  input  logic                             mul_en,
  input  logic signed [WORD_WIDTH_IN-1:0]  pixel,
  input  logic signed [WORD_WIDTH_IN-1:0]  weight,
  input  logic                             clear_sum,
  input  logic                             shift_en,
  input  logic                             take_neighbor,
  input  logic signed [WORD_WIDTH_OUT-1:0] neighbor_sum,
  output logic signed [WORD_WIDTH_OUT-1:0] sum
);

  typedef struct packed {
    logic                            vld;
    logic signed [WORD_WIDTH_IN-1:0] px;
    logic signed [WORD_WIDTH_IN-1:0] wt;
  } opnd_t;

  typedef struct packed {
    logic                             vld;
    logic                             clr;
    logic signed [WORD_WIDTH_OUT-1:0] p;
  } acc_in_t;

  opnd_t                              op_d;
  opnd_t                              op_q;
  logic                               prod_v;
  logic signed [2*WORD_WIDTH_IN-1:0]  prod;
  logic signed [WORD_WIDTH_OUT-1:0]   prod_ext;
  acc_in_t                            acc_d;
  acc_in_t                            acc_q;

  // ----------------------------------------
  // Multiplier
  // ----------------------------------------
  assign op_d = '{vld: mul_en, px: pixel, wt: weight};

  delay_line #(.payload_t(opnd_t), .N(LATENCY_MUL - 1)) op_dly_i (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (clken),
    .d      (op_d),
    .q      (op_q)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_v <= 1'b0;
    end else if (clken) begin
      prod_v <= op_q.vld;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      prod <= op_q.px * op_q.wt;  // Last multiplier stage.
    end
  end

  // ----------------------------------------
  // Accumulator
  // ----------------------------------------
  assign prod_ext = prod;  // Sign extension.
  assign acc_d    = '{vld: prod_v, clr: clear_sum, p: prod_ext};

  delay_line #(.payload_t(acc_in_t), .N(LATENCY_ACC)) acc_dly_i (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (clken),
    .d      (acc_d),
    .q      (acc_q)
  );

  always_ff @(posedge clk) begin
    if (clken) begin
      if (shift_en) begin
        if (take_neighbor) begin
          sum <= sum + neighbor_sum;  // Column merge for kernel width 3.
        end
      end else if (acc_q.vld) begin
        sum <= acc_q.clr ? acc_q.p : sum + acc_q.p;
      end
    end
  end

endmodule

//--- src/pe_array.sv
/*
  Grid of processing elements. Row u takes pixel u, column m takes
  weight m, and each column can add the sums of the column on its left.
*/
`timescale 1ns/1ps

module pe_array #(
  parameter int ROWS           = 4,
  parameter int COLS           = 4,
  parameter int WORD_WIDTH_IN  = 8,
  parameter int WORD_WIDTH_OUT = 24,
  parameter int LATENCY_MUL    = 2,
  parameter int LATENCY_ACC    = 2
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        clken,
  input  logic                                        mul_en,
  input  logic [ROWS-1:0][WORD_WIDTH_IN-1:0]          pixels,
  input  logic [COLS-1:0][WORD_WIDTH_IN-1:0]          weights,
  input  logic                                        clear_sum,
  input  logic                                        shift_en,
  input  logic                                        acc_kw2,
  output logic [COLS-1:0][ROWS-1:0][WORD_WIDTH_OUT-1:0] sums
);

  logic [COLS-1:0]                      sum_start;
  logic [COLS-1:0]                      take_nb;
  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH_OUT-1:0] nb_sums;

  genvar u, m;

  generate
    for (m = 0; m < COLS; m++) begin : g_col
      // A column starts its own sum unless it merges into a wider kernel.
      assign sum_start[m] = (acc_kw2 == conv_pkg::kw2_k1) ||
                            ((m % conv_pkg::kw_max) == 0);
      assign take_nb[m]   = !sum_start[m];

      for (u = 0; u < ROWS; u++) begin : g_row
        if (m == 0) begin : g_edge
          assign nb_sums[m][u] = '0;  // No left neighbor.
        end else begin : g_chain
          assign nb_sums[m][u] = sums[m-1][u];
        end

        processing_element #(
          .WORD_WIDTH_IN  (WORD_WIDTH_IN),
          .WORD_WIDTH_OUT (WORD_WIDTH_OUT),
          .LATENCY_MUL    (LATENCY_MUL),
          .LATENCY_ACC    (LATENCY_ACC)
        ) pe_i (
          .clk           (clk),
          .arst_n        (arst_n),
          .clken         (clken),
          .mul_en        (mul_en),
          .pixel         (pixels[u]),
          .weight        (weights[m]),
          .clear_sum     (clear_sum),
          .shift_en      (shift_en),
          .take_neighbor (take_nb[m]),
          .neighbor_sum  (nb_sums[m][u]),
          .sum           (sums[m][u])
        );
      end
    end
  endgenerate

endmodule

//--- src/result_align.sv
/*
  Result alignment. Turns group_done into the m_valid pulse and picks
  the closing beat's last flag and pass-through flags.
*/
`timescale 1ns/1ps

module result_align (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            clken,
  input  logic                            group_done,
  input  logic                            done_last,
  input  logic [conv_pkg::user_w-1:0]     done_user,
  output logic                            m_valid,
  output logic                            m_last,
  output logic [conv_pkg::user_out_w-1:0] m_user
);

  logic take;

  // group_done holds while clken is low, so the pulse fires once.
  assign take = clken && group_done;

  // ----------------------------------------
  // Output strobes
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else begin
      m_valid <= take;
      m_last  <= take && done_last;
    end
  end

  // ----------------------------------------
  // Pass-through flags
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_user <= '0;
    end else if (take) begin
      m_user[conv_pkg::o_not_max]      <= done_user[conv_pkg::i_not_max];
      m_user[conv_pkg::o_bottom_block] <= done_user[conv_pkg::i_bottom_block];
    end
  end

endmodule

//--- src/conv_engine.sv
/*
  Convolution engine top. Beat decoder, PE grid and result alignment.
*/
`timescale 1ns/1ps

module conv_engine #(
  parameter int ROWS           = 4,
  parameter int COLS           = 4,
  parameter int WORD_WIDTH_IN  = 8,
  parameter int WORD_WIDTH_OUT = 24,
  parameter int LATENCY_MUL    = 2,
  parameter int LATENCY_ACC    = 2
) (
  input  logic                                          clk,
  input  logic                                          arst_n,
  input  logic                                          clken,
  input  logic                                          s_valid,
  input  logic                                          s_last,
  input  logic [conv_pkg::user_w-1:0]                   s_user,
  input  logic [ROWS-1:0][WORD_WIDTH_IN-1:0]            s_pixels,
  input  logic [COLS-1:0][WORD_WIDTH_IN-1:0]            s_weights,
  output logic                                          s_ready,
  output logic                                          m_valid,
  output logic                                          m_last,
  output logic [conv_pkg::user_out_w-1:0]               m_user,
  output logic [COLS-1:0][ROWS-1:0][WORD_WIDTH_OUT-1:0] m_data
);

  logic                        mul_en;
  logic                        shift_en;
  logic                        clear_sum;
  logic                        acc_kw2;
  logic                        group_done;
  logic                        done_last;
  logic [conv_pkg::user_w-1:0] done_user;

  beat_decode #(
    .LATENCY_MUL (LATENCY_MUL),
    .LATENCY_ACC (LATENCY_ACC)
  ) decode_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .clken      (clken),
    .s_valid    (s_valid),
    .s_last     (s_last),
    .s_user     (s_user),
    .s_ready    (s_ready),
    .mul_en     (mul_en),
    .shift_en   (shift_en),
    .clear_sum  (clear_sum),
    .acc_kw2    (acc_kw2),
    .group_done (group_done),
    .done_last  (done_last),
    .done_user  (done_user)
  );

  pe_array #(
    .ROWS           (ROWS),
    .COLS           (COLS),
    .WORD_WIDTH_IN  (WORD_WIDTH_IN),
    .WORD_WIDTH_OUT (WORD_WIDTH_OUT),
    .LATENCY_MUL    (LATENCY_MUL),
    .LATENCY_ACC    (LATENCY_ACC)
  ) array_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .clken     (clken),
    .mul_en    (mul_en),
    .pixels    (s_pixels),
    .weights   (s_weights),
    .clear_sum (clear_sum),
    .shift_en  (shift_en),
    .acc_kw2   (acc_kw2),
    .sums      (m_data)
  );

  result_align result_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .clken      (clken),
    .group_done (group_done),
    .done_last  (done_last),
    .done_user  (done_user),
    .m_valid    (m_valid),
    .m_last     (m_last),
    .m_user     (m_user)
  );

endmodule

//--- tests/tb_conv_engine.sv
/*
  Testbench for the convolution engine. Replays the beat patterns with
  random gaps in s_valid and clken and checks every result grid.
*/
`timescale 1ns/1ps

module tb_conv_engine;

  localparam int ROWS       = 4;
  localparam int COLS       = 4;
  localparam int WIN        = 8;
  localparam int WOUT       = 24;
  localparam int NUM_BEATS  = 14;
  localparam int MAX_CYCLES = 40 * NUM_BEATS + 200;

  logic                                clk;
  logic                                arst_n;
  logic                                clken;
  logic                                s_valid;
  logic                                s_last;
  logic [conv_pkg::user_w-1:0]         s_user;
  logic [ROWS-1:0][WIN-1:0]            s_pixels;
  logic [COLS-1:0][WIN-1:0]            s_weights;
  logic                                s_ready;
  logic                                m_valid;
  logic                                m_last;
  logic [conv_pkg::user_out_w-1:0]     m_user;
  logic [COLS-1:0][ROWS-1:0][WOUT-1:0] m_data;

  // Four words per beat in ctrl, pixels, weights and checksum order.
  logic [31:0]                     pat [NUM_BEATS*4];
  int                              exp_sum_q [$];
  logic                            exp_last_q [$];
  logic [conv_pkg::user_out_w-1:0] exp_user_q [$];
  int                              num_groups;
  int                              groups_seen = 0;
  int                              cycles = 0;
  logic                            drain_check;

  conv_engine #(
    .ROWS           (ROWS),
    .COLS           (COLS),
    .WORD_WIDTH_IN  (WIN),
    .WORD_WIDTH_OUT (WOUT),
    .LATENCY_MUL    (2),
    .LATENCY_ACC    (2)
  ) dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .clken     (clken),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_user    (s_user),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .s_ready   (s_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_user    (m_user),
    .m_data    (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    begin
      $display("%s", what);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at the first error");
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  task automatic build_expected();
    int                    acc [COLS][ROWS];
    int                    merged;
    int                    total;
    logic [31:0]           ctrl;
    logic signed [WIN-1:0] px;
    logic signed [WIN-1:0] wt;
    begin
      num_groups = 0;
      for (int b = 0; b < NUM_BEATS; b++) begin
        ctrl = pat[4*b];
        for (int m = 0; m < COLS; m++) begin
          for (int u = 0; u < ROWS; u++) begin
            px = pat[4*b+1][8*u +: 8];
            wt = pat[4*b+2][8*m +: 8];
            if (ctrl[conv_pkg::i_w_first]) begin
              acc[m][u] = int'(px) * int'(wt);  // Fresh group.
            end else begin
              acc[m][u] = acc[m][u] + int'(px) * int'(wt);
            end
          end
        end
        if (ctrl[conv_pkg::i_cin_last]) begin
          total = 0;
          for (int m = 0; m < COLS; m++) begin
            for (int u = 0; u < ROWS; u++) begin
              merged = acc[m][u];
              if (ctrl[conv_pkg::i_kw2] && (m % conv_pkg::kw_max) != 0) begin
                merged = merged + acc[m-1][u];  // Left neighbor before the shift.
              end
              exp_sum_q.push_back(merged);
              total = total + merged;
            end
          end
          exp_last_q.push_back(ctrl[8]);
          exp_user_q.push_back({ctrl[conv_pkg::i_bottom_block], ctrl[conv_pkg::i_not_max]});
          assert (total == $signed(pat[4*b+3]))
            else stop_on_error($sformatf("pattern checksum of group %0d is %0d, model gives %0d",
                                         num_groups, $signed(pat[4*b+3]), total));
          num_groups++;
        end
      end
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic step_cycle(output logic taken);
    begin
      clken = ($urandom % 4) != 0;
      @(negedge clk);
      taken = s_valid && s_ready && clken;
      if (drain_check && clken) begin
        assert (s_ready == 1'b0)
          else stop_on_error($sformatf("FAILED %0t s_ready expected 0 got %b", $time, s_ready));
        drain_check = 1'b0;
      end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic drive_beat(input int b);
    logic [31:0] ctrl;
    logic        taken;
    int          gap;
    begin
      ctrl    = pat[4*b];
      gap     = $urandom % 3;
      s_valid = 1'b0;
      repeat (gap) step_cycle(taken);
      s_valid   = 1'b1;
      s_last    = ctrl[8];
      s_user    = ctrl[conv_pkg::user_w-1:0];
      s_pixels  = pat[4*b+1];
      s_weights = pat[4*b+2];
      taken     = 1'b0;
      while (!taken) begin
        step_cycle(taken);
      end
      s_valid = 1'b0;
      if (ctrl[conv_pkg::i_cin_last] && ctrl[conv_pkg::i_kw2]) begin
        drain_check = 1'b1;  // Expect the drain stall.
      end
    end
  endtask

  // ----------------------------------------
  // Output check
  // ----------------------------------------
  always @(negedge clk) begin : check_output
    int                              exp_v;
    logic signed [WOUT-1:0]          got;
    logic                            exp_l;
    logic [conv_pkg::user_out_w-1:0] exp_u;
    if (arst_n && m_valid) begin
      assert (exp_last_q.size() > 0)
        else stop_on_error("m_valid pulsed with no group outstanding");
      for (int m = 0; m < COLS; m++) begin
        for (int u = 0; u < ROWS; u++) begin
          exp_v = exp_sum_q.pop_front();
          got   = m_data[m][u];
          assert (got == exp_v)
            else stop_on_error($sformatf("FAILED %0t m_data[%0d][%0d] expected %0d got %0d",
                                         $time, m, u, exp_v, got));
        end
      end
      exp_l = exp_last_q.pop_front();
      exp_u = exp_user_q.pop_front();
      assert (m_last == exp_l)
        else stop_on_error($sformatf("FAILED %0t m_last expected %b got %b",
                                     $time, exp_l, m_last));
      assert (m_user == exp_u)
        else stop_on_error($sformatf("FAILED %0t m_user expected %b got %b",
                                     $time, exp_u, m_user));
      groups_seen++;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_on_error($sformatf("timeout after %0d cycles with %0d of %0d groups seen",
                              cycles, groups_seen, num_groups));
    end
  end

  initial begin
    void'($urandom(21380));
    arst_n      = 1'b0;
    clken       = 1'b0;
    s_valid     = 1'b0;
    s_last      = 1'b0;
    s_user      = '0;
    s_pixels    = '0;
    s_weights   = '0;
    drain_check = 1'b0;
    $readmemh("tests/conv_patterns.hex", pat);
    build_expected();

    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;
    clken  = 1'b1;
    @(negedge clk);
    assert (s_ready == 1'b1)
      else stop_on_error($sformatf("FAILED %0t s_ready expected 1 got %b", $time, s_ready));
    assert (m_valid == 1'b0)
      else stop_on_error($sformatf("FAILED %0t m_valid expected 0 got %b", $time, m_valid));
    @(posedge clk);
    #2;

    for (int b = 0; b < NUM_BEATS; b++) begin
      drive_beat(b);
    end
    s_valid = 1'b0;
    clken   = 1'b1;
    wait (groups_seen == num_groups);
    repeat (10) @(posedge clk);  // Quiet period to catch extra pulses.

    if (groups_seen == num_groups && exp_sum_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d of %0d groups arrived", groups_seen, num_groups));
    end
  end

endmodule

//--- tests/conv_patterns.hex
// One beat per line: ctrl pixels weights check. ctrl bit 8 is s_last, bits 5:0 the user word.
// Byte k of pixels is row k, byte k of weights is column k, check is the group's grid total.
// Group 1, kernel width 1, single beat.
10d 01020304 01010101 00000028
// Group 2, kernel width 1, negative and zero operands.
008 fffe0005 02ff0300 00000000
000 80010101 01000000 00000000
006 0a0a0a0a fdfdfdfd fffffdab
// Group 3, kernel width 1, back to back with group 2.
008 05050505 01020304 00000000
107 01010101 ffffffff 000000b8
// Group 4, kernel width 3.
018 01020304 04030201 00000000
115 fffffffe 01010101 00000064
// Group 5, kernel width 1, extreme operands.
10f 7f7f7f7f 81818181 fffc0ff0
// Group 6, kernel width 3.
018 00000000 7f7f7f7f 00000000
010 02020202 00ff0201 00000000
016 0300fd01 05050505 00000046
// Group 7, kernel width 1.
008 10101010 01010101 00000000
105 01000000 00000080 00000080

//--- verilog.f
src/conv_pkg.sv
src/delay_line.sv
src/beat_decode.sv
src/processing_element.sv
src/pe_array.sv
src/result_align.sv
src/conv_engine.sv
tests/tb_conv_engine.sv

//--- Bender.yml
package:
  name: conv_engine

sources:
  - files:
      - src/conv_pkg.sv
      - src/delay_line.sv
      - src/beat_decode.sv
      - src/processing_element.sv
      - src/pe_array.sv
      - src/result_align.sv
      - src/conv_engine.sv
  - target: test
    files:
      - tests/tb_conv_engine.sv
